// File: all.f
+incdir+source
source/stripe_pkg.sv
source/str_gbox.sv
source/str_dispatch.sv
source/str_collect.sv
source/str_stripe_top.sv
verification/str_stripe_tb.sv

// File: run.sh
#!/bin/bash
# compile and run the striped packer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module str_stripe_tb -Mdir obj_dir -o str_stripe_sim -f all.f

./obj_dir/str_stripe_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: verification/str_stripe_tb.sv
`timescale 1ns/1ps

`include "stripe_cfg.svh"

module str_stripe_tb;

    // cycles without any transfer before a traffic run gives up
    localparam int IDLE_LIMIT = 200;

    logic                           clk;
    logic                           rst;
    logic [`STRIPE_UP_WIDTH-1:0]    up_data_i;
    logic                           up_last_i;
    logic                           up_val_i;
    logic                           up_rdy_o;
    logic [`STRIPE_DN_WIDTH-1:0]    dn_data_o;
    logic                           dn_last_o;
    stripe_pkg::byte_cnt_t          dn_cnt_o;
    logic                           dn_val_o;
    logic                           dn_rdy_i;

    // bytes still to be sent, one last flag per byte
    logic [`STRIPE_UP_WIDTH-1:0]    src_data [$];
    bit                             src_last [$];

    // model of the output stream, one entry per packed word in packet order
    logic [`STRIPE_DN_WIDTH-1:0]    exp_data [$];
    bit                             exp_last [$];
    int                             exp_cnt [$];

    logic [15:0]                    lfsr_state;
    int                             err_count;
    int                             pass_count;
    int                             fail_count;
    int                             stall_checks;
    int                             stall_errs;

    str_stripe_top dut (
        .clk       (clk),
        .rst       (rst),
        .up_data_i (up_data_i),
        .up_last_i (up_last_i),
        .up_val_i  (up_val_i),
        .up_rdy_o  (up_rdy_o),
        .dn_data_o (dn_data_o),
        .dn_last_o (dn_last_o),
        .dn_cnt_o  (dn_cnt_o),
        .dn_val_o  (dn_val_o),
        .dn_rdy_i  (dn_rdy_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // the register steps once for every bit handed out
    function automatic int unsigned rand_bits(input int nbits);
        int unsigned val;
        val = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | 32'(lfsr_state[0]);
        end
        return val;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
            err_count++;
        end
    endtask

    // queue one packet of random bytes and the words it should turn into
    // bytes fill a word from the low end and a short last word keeps zeros above
    task automatic add_packet(input int len);
        logic [`STRIPE_UP_WIDTH-1:0] b;
        logic [`STRIPE_DN_WIDTH-1:0] word;
        int                          pos;
        word = '0;
        for (int i = 0; i < len; i++) begin
            b   = `STRIPE_UP_WIDTH'(rand_bits(`STRIPE_UP_WIDTH));
            pos = i % `STRIPE_BYTES;
            src_data.push_back(b);
            src_last.push_back(i == len - 1);
            word[pos*`STRIPE_UP_WIDTH +: `STRIPE_UP_WIDTH] = b;
            // a word closes when full or when the packet ends
            if (pos == `STRIPE_BYTES - 1 || i == len - 1) begin
                exp_data.push_back(word);
                exp_last.push_back(i == len - 1);
                exp_cnt.push_back(pos + 1);
                word = '0;
            end
        end
    endtask

    // handshakes are judged at the falling edge, where every DUT output has
    // settled, and the inputs change on the following rising edge
    task automatic run_traffic(input string name, input bit use_gaps, input bit use_stalls);
        bit                          in_fire;
        bit                          out_fire;
        bit                          holding;
        bit                          gap;
        bit                          stalled;
        logic [`STRIPE_DN_WIDTH-1:0] held_data;
        logic                        held_last;
        stripe_pkg::byte_cnt_t       held_cnt;
        int                          idle;
        int                          mark;
        stalled = 1'b0;
        idle    = 0;
        while (exp_data.size() > 0 && idle < IDLE_LIMIT) begin
            @(negedge clk);
            in_fire  = up_val_i && up_rdy_o;
            out_fire = dn_val_o && dn_rdy_i;
            holding  = up_val_i && !up_rdy_o;

            // a word that was refused last cycle must still be offered unchanged
            if (stalled) begin
                mark = err_count;
                stall_checks++;
                check_value("dn_val_o", 32'd1, 32'(dn_val_o));
                check_value("dn_data_o", held_data, dn_data_o);
                check_value("dn_last_o", 32'(held_last), 32'(dn_last_o));
                check_value("dn_cnt_o", 32'(held_cnt), 32'(dn_cnt_o));
                stall_errs += err_count - mark;
            end
            stalled   = dn_val_o && !dn_rdy_i;
            held_data = dn_data_o;
            held_last = dn_last_o;
            held_cnt  = dn_cnt_o;

            if (out_fire) begin
                check_value("dn_data_o", exp_data[0], dn_data_o);
                check_value("dn_last_o", 32'(exp_last[0]), 32'(dn_last_o));
                check_value("dn_cnt_o", 32'(exp_cnt[0]), 32'(dn_cnt_o));
                exp_data.delete(0);
                exp_last.delete(0);
                exp_cnt.delete(0);
            end

            if (in_fire || out_fire) begin
                idle = 0;
            end else begin
                idle++;
            end

            @(posedge clk);
            if (in_fire) begin
                src_data.delete(0);
                src_last.delete(0);
            end
            // a byte on offer stays there until it is taken
            if (!holding) begin
                gap = use_gaps && (rand_bits(2) == 0);
                if (src_data.size() > 0 && !gap) begin
                    up_val_i  <= 1'b1;
                    up_data_i <= src_data[0];
                    up_last_i <= src_last[0];
                end else begin
                    up_val_i <= 1'b0;
                end
            end
            if (use_stalls) begin
                dn_rdy_i <= (rand_bits(2) != 0);
            end else begin
                dn_rdy_i <= 1'b1;
            end
        end
        if (exp_data.size() > 0) begin
            $display("%s timed out: no transfer for %0d cycles, %0d words never arrived",
                     name, IDLE_LIMIT, exp_data.size());
            err_count++;
            src_data.delete();
            src_last.delete();
            exp_data.delete();
            exp_last.delete();
            exp_cnt.delete();
            up_val_i <= 1'b0;
        end
    endtask

    task automatic finish_test(input string name, input int mark);
        if (err_count == mark) begin
            pass_count++;
            $display("%s: PASS", name);
        end else begin
            fail_count++;
            $display("%s: FAIL with %0d errors", name, err_count - mark);
        end
    endtask

    initial begin
        int mark;
        lfsr_state   = 16'd76;
        err_count    = 0;
        pass_count   = 0;
        fail_count   = 0;
        stall_checks = 0;
        stall_errs   = 0;
        rst          = 1'b1;
        up_data_i    = '0;
        up_last_i    = 1'b0;
        up_val_i     = 1'b0;
        dn_rdy_i     = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // an idle input with no downstream ready leaves every ready and valid low
        mark = err_count;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_value("up_rdy_o", 32'd0, 32'(up_rdy_o));
            check_value("dn_val_o", 32'd0, 32'(dn_val_o));
        end
        finish_test("test 1 reset and idle", mark);

        // six packets wrap the pointers once around the four lanes
        mark = err_count;
        add_packet(4);
        add_packet(8);
        add_packet(12);
        add_packet(4);
        add_packet(8);
        add_packet(12);
        run_traffic("test 2 full words", 1'b0, 1'b0);
        finish_test("test 2 full words", mark);

        mark = err_count;
        add_packet(1);
        add_packet(2);
        add_packet(3);
        add_packet(5);
        add_packet(7);
        run_traffic("test 3 partial words", 1'b0, 1'b0);
        finish_test("test 3 partial words", mark);

        // lengths from 1 to 13, so some packets span four words
        mark = err_count;
        for (int i = 0; i < 200; i++) begin
            add_packet(int'(rand_bits(4) % 13) + 1);
        end
        run_traffic("test 4 random traffic", 1'b1, 1'b1);
        finish_test("test 4 random traffic", mark);

        // stalled words were checked while test 4 ran
        if (stall_checks == 0) begin
            $display("test 5 saw no stalled output word, so hold behavior was not exercised");
            fail_count++;
            err_count++;
        end else if (stall_errs == 0) begin
            pass_count++;
            $display("test 5 output hold under back-pressure: PASS over %0d stalled cycles",
                     stall_checks);
        end else begin
            fail_count++;
            $display("test 5 output hold under back-pressure: FAIL with %0d errors",
                     stall_errs);
        end

        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: source/str_stripe_top.sv
`timescale 1ns/1ps

`include "stripe_cfg.svh"

module str_stripe_top (
    input  logic                           clk,
    input  logic                           rst,

    input  logic [`STRIPE_UP_WIDTH-1:0]    up_data_i,
    input  logic                           up_last_i,
    input  logic                           up_val_i,
    output logic                           up_rdy_o,

    output logic [`STRIPE_DN_WIDTH-1:0]    dn_data_o,
    output logic                           dn_last_o,
    output stripe_pkg::byte_cnt_t          dn_cnt_o,
    output logic                           dn_val_o,
    input  logic                           dn_rdy_i
);

    // byte side, shared data and last with one valid and ready per lane
    logic [`STRIPE_UP_WIDTH-1:0]    lane_data;
    logic                           lane_last;
    logic [`STRIPE_LANES-1:0]       lane_val;
    logic [`STRIPE_LANES-1:0]       lane_rdy;

    // word side, one full stream per lane
    logic [`STRIPE_DN_WIDTH-1:0]    word_data [`STRIPE_LANES];
    logic [`STRIPE_LANES-1:0]       word_last;
    stripe_pkg::byte_cnt_t          word_cnt [`STRIPE_LANES];
    logic [`STRIPE_LANES-1:0]       word_val;
    logic [`STRIPE_LANES-1:0]       word_rdy;

    str_dispatch u_dispatch (
        .clk         (clk),
        .rst         (rst),
        .up_data_i   (up_data_i),
        .up_last_i   (up_last_i),
        .up_val_i    (up_val_i),
        .up_rdy_o    (up_rdy_o),
        .lane_data_o (lane_data),
        .lane_last_o (lane_last),
        .lane_val_o  (lane_val),
        .lane_rdy_i  (lane_rdy)
    );

    // each lane packs whole packets, so lanes never share a word
    for (genvar gi = 0; gi < `STRIPE_LANES; gi++) begin : g_lane
        str_gbox u_gbox (
            .clk       (clk),
            .rst       (rst),
            .up_data_i (lane_data),
            .up_last_i (lane_last),
            .up_val_i  (lane_val[gi]),
            .up_rdy_o  (lane_rdy[gi]),
            .dn_data_o (word_data[gi]),
            .dn_last_o (word_last[gi]),
            .dn_cnt_o  (word_cnt[gi]),
            .dn_val_o  (word_val[gi]),
            .dn_rdy_i  (word_rdy[gi])
        );
    end

    str_collect u_collect (
        .clk         (clk),
        .rst         (rst),
        .word_data_i (word_data),
        .word_last_i (word_last),
        .word_cnt_i  (word_cnt),
        .word_val_i  (word_val),
        .word_rdy_o  (word_rdy),
        .dn_data_o   (dn_data_o),
        .dn_last_o   (dn_last_o),
        .dn_cnt_o    (dn_cnt_o),
        .dn_val_o    (dn_val_o),
        .dn_rdy_i    (dn_rdy_i)
    );

endmodule

// File: source/str_collect.sv
`timescale 1ns/1ps

`include "stripe_cfg.svh"

module str_collect (
    input  logic                           clk,
    input  logic                           rst,

    input  logic [`STRIPE_DN_WIDTH-1:0]    word_data_i [`STRIPE_LANES],
    input  logic [`STRIPE_LANES-1:0]       word_last_i,
    input  stripe_pkg::byte_cnt_t          word_cnt_i [`STRIPE_LANES],
    input  logic [`STRIPE_LANES-1:0]       word_val_i,
    output logic [`STRIPE_LANES-1:0]       word_rdy_o,

    output logic [`STRIPE_DN_WIDTH-1:0]    dn_data_o,
    output logic                           dn_last_o,
    output stripe_pkg::byte_cnt_t          dn_cnt_o,
    output logic                           dn_val_o,
    input  logic                           dn_rdy_i
);

    localparam logic [`STRIPE_LANE_W-1:0] LAST_LANE = `STRIPE_LANE_W'(`STRIPE_LANES - 1);

    // lane whose packet is next in arrival order
    logic [`STRIPE_LANE_W-1:0] coll_ptr;
    logic                      pkt_done;

    // the output packet ends on a transfer that carries last
    assign pkt_done = dn_val_o & dn_rdy_i & dn_last_o;

    // same round-robin walk as the dispatcher, so order is kept
    always_ff @(posedge clk) begin
        if (rst) begin
            coll_ptr <= '0;
        end else if (pkt_done) begin
            if (coll_ptr == LAST_LANE) begin
                coll_ptr <= '0;
            end else begin
                coll_ptr <= coll_ptr + 1'b1;
            end
        end
    end

    // the selected lane drives the output directly
    assign dn_data_o = word_data_i[coll_ptr];
    assign dn_last_o = word_last_i[coll_ptr];
    assign dn_cnt_o  = word_cnt_i[coll_ptr];
    assign dn_val_o  = word_val_i[coll_ptr];

    // other lanes see ready low and keep their words
    always_comb begin
        word_rdy_o           = '0;
        word_rdy_o[coll_ptr] = dn_rdy_i;
    end

    // the pointer cannot move to another lane while the output is stalled
    // so a refused word stays on the output unchanged until it is taken
    a_out_hold: assert property (
        @(posedge clk) disable iff (rst)
        dn_val_o && !dn_rdy_i |=>
            dn_val_o && $stable(dn_data_o) && $stable(dn_last_o) && $stable(dn_cnt_o)
    );

endmodule

// File: source/str_dispatch.sv
`timescale 1ns/1ps

`include "stripe_cfg.svh"

module str_dispatch (
    input  logic                           clk,
    input  logic                           rst,

    input  logic [`STRIPE_UP_WIDTH-1:0]    up_data_i,
    input  logic                           up_last_i,
    input  logic                           up_val_i,
    output logic                           up_rdy_o,

    output logic [`STRIPE_UP_WIDTH-1:0]    lane_data_o,
    output logic                           lane_last_o,
    output logic [`STRIPE_LANES-1:0]       lane_val_o,
    input  logic [`STRIPE_LANES-1:0]       lane_rdy_i
);

    localparam logic [`STRIPE_LANE_W-1:0] LAST_LANE = `STRIPE_LANE_W'(`STRIPE_LANES - 1);

    // lane that receives the packet currently on the input
    logic [`STRIPE_LANE_W-1:0] disp_ptr;
    logic                      pkt_done;

    // a packet ends on the beat that carries last
    assign pkt_done = up_val_i & up_rdy_o & up_last_i;

    // pointer steps round-robin once per packet
    always_ff @(posedge clk) begin
        if (rst) begin
            disp_ptr <= '0;
        end else if (pkt_done) begin
            if (disp_ptr == LAST_LANE) begin
                disp_ptr <= '0;
            end else begin
                disp_ptr <= disp_ptr + 1'b1;
            end
        end
    end

    // data and last go to every lane, the valid decides who takes them
    assign lane_data_o = up_data_i;
    assign lane_last_o = up_last_i;

    // only the selected lane is offered the byte
    always_comb begin
        lane_val_o           = '0;
        lane_val_o[disp_ptr] = up_val_i;
    end

    // the input stalls exactly as the selected lane does
    assign up_rdy_o = lane_rdy_i[disp_ptr];

    // a byte that waits for its lane stays on the input unchanged
    // so the lane takes exactly the byte the source offered
    a_up_hold: assert property (
        @(posedge clk) disable iff (rst)
        up_val_i && !up_rdy_o |=>
            up_val_i && $stable(up_data_i) && $stable(up_last_i)
    );

endmodule

// File: source/str_gbox.sv
`timescale 1ns/1ps

`include "stripe_cfg.svh"

module str_gbox (
    input  logic                           clk,
    input  logic                           rst,

    input  logic [`STRIPE_UP_WIDTH-1:0]    up_data_i,
    input  logic                           up_last_i,
    input  logic                           up_val_i,
    output logic                           up_rdy_o,

    output logic [`STRIPE_DN_WIDTH-1:0]    dn_data_o,
    output logic                           dn_last_o,
    output stripe_pkg::byte_cnt_t          dn_cnt_o,
    output logic                           dn_val_o,
    input  logic                           dn_rdy_i
);

    localparam int DATA_NB = `STRIPE_BYTES;

    // skid register, holds a byte taken in the cycle that ready was falling
    logic                           skid_val;
    logic                           skid_last;
    logic [`STRIPE_UP_WIDTH-1:0]    skid_data;

    // byte seen by the packer, either straight from the input or from the skid
    logic                           in_val;
    logic                           in_last;
    logic [`STRIPE_UP_WIDTH-1:0]    in_data;

    // one-hot write position inside the word being packed
    logic [DATA_NB-1:0]             token;
    stripe_pkg::byte_cnt_t          tok_cnt;

    logic                           dn_active;
    logic                           take;

    // the output register may move when it is empty or when it is being drained
    assign dn_active = ~dn_val_o | dn_rdy_i;

    // while ready is low the skid register stands in for the input
    assign in_data = up_rdy_o ? up_data_i : skid_data;
    assign in_last = up_rdy_o ? up_last_i : skid_last;
    assign in_val  = up_rdy_o ? up_val_i  : skid_val;

    // a byte enters the word only when the output side can move
    assign take = dn_active & in_val;

    // the skid always samples what the packer saw, so while ready is low it
    // simply keeps its own value
    always_ff @(posedge clk) begin
        skid_data <= in_data;
    end

    // valid and last stay in the skid until the packer consumes them
    always_ff @(posedge clk) begin
        if (rst) begin
            skid_val  <= 1'b0;
            skid_last <= 1'b0;
        end else begin
            skid_val  <= in_val & ~dn_active;
            skid_last <= in_last & ~dn_active;
        end
    end

    // ready is registered and follows the output side
    // it only updates when there is something to react to, so an idle lane
    // keeps whatever it last decided
    always_ff @(posedge clk) begin
        if (rst) begin
            up_rdy_o <= 1'b0;
        end else if (dn_rdy_i | up_val_i) begin
            up_rdy_o <= dn_active;
        end
    end

    // the token walks from the low byte to the high byte and wraps
    // a byte with last sends it back to position 0 for the next packet
    always_ff @(posedge clk) begin
        if (rst) begin
            token <= DATA_NB'(1);
        end else if (take) begin
            if (in_last) begin
                token <= DATA_NB'(1);
            end else begin
                token <= {token[DATA_NB-2:0], token[DATA_NB-1]};
            end
        end
    end

    // number of bytes in the word once the byte at the token is written
    always_comb begin
        tok_cnt = '0;
        for (int ii = 0; ii < DATA_NB; ii++) begin
            if (token[ii]) begin
                tok_cnt = stripe_pkg::byte_cnt_t'(ii + 1);
            end
        end
    end

    // a word goes out after its top byte or after the final byte of a packet
    always_ff @(posedge clk) begin
        if (rst) begin
            dn_val_o  <= 1'b0;
            dn_last_o <= 1'b0;
        end else if (dn_active) begin
            dn_val_o  <= in_val & (token[DATA_NB-1] | in_last);
            dn_last_o <= in_val & in_last;
        end
    end

    // count follows the token, it is frozen with the data while stalled
    always_ff @(posedge clk) begin
        if (take) begin
            dn_cnt_o <= tok_cnt;
        end
    end

    // the first byte of a word clears the rest, so a short last word is
    // padded with zeros above the final byte
    always_ff @(posedge clk) begin
        for (int ii = 0; ii < DATA_NB; ii++) begin
            if (take & token[0]) begin
                dn_data_o[ii*`STRIPE_UP_WIDTH +: `STRIPE_UP_WIDTH] <= '0;
            end
            if (take & token[ii]) begin
                dn_data_o[ii*`STRIPE_UP_WIDTH +: `STRIPE_UP_WIDTH] <= in_data;
            end
        end
    end

    // a stalled word must not change under the collector
    a_dn_stable: assert property (
        @(posedge clk) disable iff (rst)
        dn_val_o && !dn_rdy_i |=>
            $stable(dn_data_o) && $stable(dn_last_o) && $stable(dn_cnt_o)
    );

    // a word is never withdrawn before it has been taken
    a_dn_hold: assert property (
        @(posedge clk) disable iff (rst)
        $fell(dn_val_o) |-> $past(dn_rdy_i)
    );

endmodule

// File: source/stripe_pkg.sv
`include "stripe_cfg.svh"

package stripe_pkg;

    // count of valid bytes in one packed output word
    // a full word reports STRIPE_BYTES and a partial last word reports
    // only the bytes that the packet really filled, so it runs from 1 up
    // the width is one bit wider than needed to index a byte, which leaves
    // room for the full count itself
    typedef logic [$clog2(`STRIPE_BYTES + 1)-1:0] byte_cnt_t;

endpackage

// File: source/stripe_cfg.svh
`ifndef STRIPE_CFG_SVH
`define STRIPE_CFG_SVH

// width of one byte on the input stream
`define STRIPE_UP_WIDTH 8

// width of one packed word on the output stream
`define STRIPE_DN_WIDTH 32

// input bytes that fill one output word
`define STRIPE_BYTES 4

// number of gearbox lanes that packets are striped across
// any value of 2 or more works as long as STRIPE_LANE_W can hold it
`define STRIPE_LANES 4

// width of the dispatch and collect pointers
`define STRIPE_LANE_W 2

`endif
